//--- hw/rv_core_settings.svh
/* Core-wide settings: data width, register count and reset pc */

`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// Data and address width
`define RV_XLEN 32

// Architectural register count, x0 included
`define RV_NREGS 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

//--- hw/rv_core_pkg.sv
/* Core types: word, register index, ALU control, writeback select, immediate format */

`include "rv_core_settings.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0]          word_t;     // Data or address word
    typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t; // Register index

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,                              // a + b
        ALU_SUB = 3'b001,                              // a - b
        ALU_AND = 3'b010,                              // a & b
        ALU_OR  = 3'b011,                              // a | b
        ALU_SLT = 3'b101                               // Signed a < b
    } alu_op_t;

    typedef enum logic [1:0] {
        AOP_ADD   = 2'b00,                             // jal, add only
        AOP_SUB   = 2'b01,                             // beq compare
        AOP_FUNCT = 2'b10                              // R and I type, by funct
    } aluop_class_t;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,                               // ALU result
        RES_PC4 = 2'b01                                // Link value pc + 4
    } result_src_t;

    typedef enum logic [1:0] {
        IMM_I = 2'b00,                                 // I format
        IMM_S = 2'b01,                                 // Reserved, no stores
        IMM_B = 2'b10,                                 // Branch offset
        IMM_J = 2'b11                                  // Jump offset
    } imm_src_t;

endpackage

//--- hw/maindec.sv
/* Main decoder: opcode to datapath controls and ALU operation class */

`timescale 1ns/1ps

module maindec import rv_core_pkg::*; (
    input  logic [6:0]   i_op,          // Instruction opcode
    output result_src_t  o_resultsrc,   // Writeback select
    output imm_src_t     o_immsrc,      // Immediate format
    output logic         o_alusrc,      // 1 selects immediate as ALU b
    output logic         o_regwrite,    // Register write, ungated
    output logic         o_branch,      // beq
    output logic         o_jump,        // jal
    output aluop_class_t o_aluop        // Class for ALU decoder
);

    localparam logic [6:0] OP_RTYPE  = 7'b0110011;   // add sub and or slt
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;   // addi andi ori slti
    localparam logic [6:0] OP_BRANCH = 7'b1100011;   // beq
    localparam logic [6:0] OP_JAL    = 7'b1101111;   // jal

    always_comb begin
        // No-operation set, used for every unsupported opcode
        o_resultsrc = RES_ALU;
        o_immsrc    = IMM_I;
        o_alusrc    = 1'b0;
        o_regwrite  = 1'b0;
        o_branch    = 1'b0;
        o_jump      = 1'b0;
        o_aluop     = AOP_ADD;

        case (i_op)
            OP_RTYPE: begin
                o_regwrite = 1'b1;            // rd <- rs1 op rs2
                o_aluop    = AOP_FUNCT;
            end
            OP_ITYPE: begin
                o_regwrite = 1'b1;            // rd <- rs1 op imm
                o_alusrc   = 1'b1;
                o_immsrc   = IMM_I;
                o_aluop    = AOP_FUNCT;
            end
            OP_BRANCH: begin
                o_branch   = 1'b1;            // Compare by subtract
                o_immsrc   = IMM_B;
                o_aluop    = AOP_SUB;
            end
            OP_JAL: begin
                o_jump      = 1'b1;
                o_regwrite  = 1'b1;           // Link register
                o_immsrc    = IMM_J;
                o_resultsrc = RES_PC4;
            end
            default: ;                        // Retire as nop
        endcase
    end

endmodule

//--- hw/aludec.sv
/* ALU decoder: operation class and funct fields to ALU control */

`timescale 1ns/1ps

module aludec import rv_core_pkg::*; (
    input  logic         i_opb5,        // Opcode bit 5, high for R-type
    input  logic         i_funct7b5,    // funct7 bit 5, sub select
    input  logic [2:0]   i_funct3,      // funct3 field
    input  aluop_class_t i_aluop,       // Class from main decoder
    output alu_op_t      o_alucrtl      // ALU operation
);

    logic l_rtype_sub;                  // R-type with funct7 sub bit

    assign l_rtype_sub = i_opb5 & i_funct7b5;

    always_comb begin
        case (i_aluop)
            AOP_ADD: o_alucrtl = ALU_ADD;              // jal
            AOP_SUB: o_alucrtl = ALU_SUB;              // beq
            AOP_FUNCT: begin
                case (i_funct3)
                    3'b000: begin
                        if (l_rtype_sub) begin
                            o_alucrtl = ALU_SUB;       // sub
                        end else begin
                            o_alucrtl = ALU_ADD;       // add, addi
                        end
                    end
                    3'b010:  o_alucrtl = ALU_SLT;      // slt, slti
                    3'b110:  o_alucrtl = ALU_OR;       // or, ori
                    3'b111:  o_alucrtl = ALU_AND;      // and, andi
                    default: o_alucrtl = ALU_ADD;      // Unsupported funct3
                endcase
            end
            default: o_alucrtl = ALU_ADD;
        endcase
    end

    // funct7 bit 5 is ignored for I-type since addi has no subtract form

endmodule

//--- hw/controller.sv
/* Decode controller with main and ALU decoders, immediate extender and branch decision */

`timescale 1ns/1ps

module controller import rv_core_pkg::*; (
    input  word_t       i_instr,        // Instruction register
    input  logic        i_zero,         // ALU zero flag
    input  logic        i_exec,         // Execute strobe
    output alu_op_t     o_alucrtl,      // ALU operation
    output result_src_t o_resultsrc,    // Writeback select
    output logic        o_alusrc,       // Immediate as ALU b
    output logic        o_regwrite,     // Write enable gated by exec
    output logic        o_take,         // Load pc + imm
    output word_t       o_imm           // Sign-extended immediate
);

    imm_src_t     l_immsrc;             // Format from main decoder
    aluop_class_t l_aluop;              // ALU class from main decoder
    logic         l_regwrite;           // Ungated write enable
    logic         l_branch;             // beq
    logic         l_jump;               // jal

    maindec u_maindec (
        .i_op        (i_instr[6:0]),
        .o_resultsrc (o_resultsrc),
        .o_immsrc    (l_immsrc),
        .o_alusrc    (o_alusrc),
        .o_regwrite  (l_regwrite),
        .o_branch    (l_branch),
        .o_jump      (l_jump),
        .o_aluop     (l_aluop)
    );

    aludec u_aludec (
        .i_opb5     (i_instr[5]),
        .i_funct7b5 (i_instr[30]),
        .i_funct3   (i_instr[14:12]),
        .i_aluop    (l_aluop),
        .o_alucrtl  (o_alucrtl)
    );

    // Sign bit is always instr[31]
    always_comb begin
        case (l_immsrc)
            IMM_I:   o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
            IMM_B:   o_imm = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                              i_instr[11:8], 1'b0};
            default: o_imm = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                              i_instr[30:21], 1'b0};                // IMM_J
        endcase
    end

    assign o_take     = (l_branch & i_zero) | l_jump;  // Equal beq or any jal
    assign o_regwrite = l_regwrite & i_exec;           // One write per instruction

endmodule

//--- hw/alu.sv
/* ALU: add, sub, and, or, signed slt and zero flag */

`timescale 1ns/1ps

module alu import rv_core_pkg::*; (
    input  word_t   i_a,                // rs1
    input  word_t   i_b,                // rs2 or immediate
    input  alu_op_t i_ctrl,             // Operation
    output word_t   o_result,           // Result
    output logic    o_zero              // Result is zero
);

    logic l_lt;                         // Signed less-than

    assign l_lt = $signed(i_a) < $signed(i_b);

    always_comb begin
        case (i_ctrl)
            ALU_ADD: o_result = i_a + i_b;
            ALU_SUB: o_result = i_a - i_b;      // Also beq compare
            ALU_AND: o_result = i_a & i_b;
            ALU_OR:  o_result = i_a | i_b;
            ALU_SLT: o_result = l_lt ? word_t'(1) : '0;
            default: o_result = i_a + i_b;
        endcase
    end

    assign o_zero = (o_result == '0);   // beq taken when a - b is zero

endmodule

//--- hw/regfile.sv
/* Register file: two async read ports, one clocked write port, x0 fixed at zero */

`timescale 1ns/1ps
`include "rv_core_settings.svh"

module regfile import rv_core_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_we,             // Write enable, one per instruction
    input  reg_addr_t i_ra1,            // rs1
    input  reg_addr_t i_ra2,            // rs2
    input  reg_addr_t i_wa,             // rd
    input  word_t     i_wd,             // Writeback value
    output word_t     o_rd1,            // rs1 value
    output word_t     o_rd2             // rs2 value
);

    word_t r_regs [`RV_NREGS];          // x0 never written

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                r_regs[i] <= '0;        // All registers start at zero
            end
        end else if (i_we && (i_wa != '0)) begin
            r_regs[i_wa] <= i_wd;
        end
    end

    assign o_rd1 = r_regs[i_ra1];       // Combinational reads
    assign o_rd2 = r_regs[i_ra2];

endmodule

//--- hw/pc_unit.sv
/* Program counter with sequential and branch or jump target selection */

`timescale 1ns/1ps
`include "rv_core_settings.svh"

module pc_unit import rv_core_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_advance,            // Execute strobe, update pc
    input  logic  i_take,               // Branch taken or jump
    input  word_t i_imm,                // pc-relative offset
    output word_t o_pc,                 // Fetch address
    output word_t o_pc_plus4            // Sequential pc, link value
);

    word_t r_pc;                        // Current pc
    word_t l_target;                    // pc + offset
    word_t l_pc_next;                   // Selected next pc

    assign o_pc_plus4 = r_pc + 32'd4;
    assign l_target   = r_pc + i_imm;
    assign l_pc_next  = i_take ? l_target : o_pc_plus4;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_pc <= `RV_RESET_PC;
        end else if (i_advance) begin
            r_pc <= l_pc_next;          // Same edge as register write
        end
    end

    // Stable for the whole bus request since advance only comes in EXEC
    assign o_pc = r_pc;

endmodule

//--- hw/fetch_fsm.sv
/* Fetch FSM: Wishbone classic instruction read, instruction register, execute strobe */

`timescale 1ns/1ps

module fetch_fsm import rv_core_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_wb_ack,             // Slave acknowledge
    input  word_t i_wb_dat,             // Read data
    output logic  o_wb_cyc,             // Bus cycle
    output logic  o_wb_stb,             // Strobe, same as cyc
    output logic  o_exec,               // One cycle per instruction
    output word_t o_instr               // Instruction register
);

    typedef enum logic {
        FETCH = 1'b0,                   // Request until ack
        EXEC  = 1'b1                    // Write back, pc update, retire
    } state_t;

    state_t r_state;                    // Current state
    logic   r_cyc;                      // Registered bus request
    word_t  r_instr;                    // Latched instruction, no reset

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_state <= FETCH;
            r_cyc   <= 1'b0;
        end else begin
            case (r_state)
                FETCH: begin
                    if (!r_cyc) begin
                        r_cyc <= 1'b1;              // First request after reset
                    end else if (i_wb_ack) begin
                        r_cyc   <= 1'b0;            // Drop in the next cycle
                        r_state <= EXEC;
                    end
                end
                EXEC: begin
                    r_cyc   <= 1'b1;                // Next request right away
                    r_state <= FETCH;
                end
                default: begin
                    r_cyc   <= 1'b0;
                    r_state <= FETCH;
                end
            endcase
        end
    end

    // Data is valid in the ack cycle only
    always_ff @(posedge i_clk) begin
        if ((r_state == FETCH) && r_cyc && i_wb_ack) begin
            r_instr <= i_wb_dat;
        end
    end

    assign o_wb_cyc = r_cyc;
    assign o_wb_stb = r_cyc;            // Single transfer per cycle
    assign o_exec   = (r_state == EXEC);
    assign o_instr  = r_instr;

    // The instruction stays put until the next ack, after EXEC

endmodule

//--- hw/rv_core_top.sv
/* Core top: fetch FSM, controller, register file, ALU and pc unit */

`timescale 1ns/1ps

module rv_core_top import rv_core_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_wb_ack,         // Wishbone acknowledge
    input  word_t     i_wb_dat,         // Wishbone read data
    output logic      o_wb_cyc,         // Wishbone cycle
    output logic      o_wb_stb,         // Wishbone strobe
    output word_t     o_wb_adr,         // Fetch address
    output logic      o_retire,         // Instruction retires this cycle
    output logic      o_ret_we,         // Register write performed
    output word_t     o_ret_pc,         // pc of retiring instruction
    output word_t     o_ret_data,       // Writeback value
    output reg_addr_t o_ret_rd          // Destination index
);

    word_t       l_instr;               // Instruction register
    logic        l_exec;                // Execute strobe
    alu_op_t     l_alucrtl;             // ALU operation
    result_src_t l_resultsrc;           // Writeback select
    logic        l_alusrc;              // ALU b select
    logic        l_regwrite;            // Gated write enable
    logic        l_take;                // Branch or jump taken
    logic        l_zero;                // ALU zero flag
    word_t       l_imm;                 // Immediate
    word_t       l_rd1;                 // rs1 value
    word_t       l_rd2;                 // rs2 value
    word_t       l_srcb;                // ALU b operand
    word_t       l_alu_res;             // ALU result
    word_t       l_pc;                  // Current pc
    word_t       l_pc_plus4;            // Link value
    word_t       l_wb_data;             // Writeback value

    fetch_fsm u_fetch (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_wb_ack (i_wb_ack), .i_wb_dat (i_wb_dat),
        .o_wb_cyc (o_wb_cyc), .o_wb_stb (o_wb_stb), .o_exec (l_exec), .o_instr (l_instr)
    );

    controller u_ctrl (
        .i_instr (l_instr), .i_zero (l_zero), .i_exec (l_exec), .o_alucrtl (l_alucrtl),
        .o_resultsrc (l_resultsrc), .o_alusrc (l_alusrc), .o_regwrite (l_regwrite),
        .o_take (l_take), .o_imm (l_imm)
    );

    regfile u_rf (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_we (l_regwrite),
        .i_ra1 (l_instr[19:15]), .i_ra2 (l_instr[24:20]), .i_wa (l_instr[11:7]),
        .i_wd (l_wb_data), .o_rd1 (l_rd1), .o_rd2 (l_rd2)
    );

    assign l_srcb = l_alusrc ? l_imm : l_rd2;   // Immediate or rs2

    alu u_alu (
        .i_a (l_rd1), .i_b (l_srcb), .i_ctrl (l_alucrtl), .o_result (l_alu_res), .o_zero (l_zero)
    );

    pc_unit u_pc (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_advance (l_exec), .i_take (l_take),
        .i_imm (l_imm), .o_pc (l_pc), .o_pc_plus4 (l_pc_plus4)
    );

    assign l_wb_data = (l_resultsrc == RES_PC4) ? l_pc_plus4 : l_alu_res;  // jal link

    assign o_wb_adr   = l_pc;
    assign o_retire   = l_exec;         // Retire in EXEC, writes land on its closing edge
    assign o_ret_pc   = l_pc;
    assign o_ret_rd   = l_instr[11:7];
    assign o_ret_we   = l_regwrite;
    assign o_ret_data = l_wb_data;

endmodule

//--- verification/rv_core_props.sv
/* Bound checks of the Wishbone request hold, address hold and one-cycle retire */

`timescale 1ns/1ps

module rv_core_props import rv_core_pkg::*; (
    input logic  i_clk,
    input logic  i_rst_n,
    input logic  i_wb_ack,              // Slave acknowledge
    input logic  i_wb_cyc,              // Core bus cycle
    input logic  i_wb_stb,              // Core strobe
    input word_t i_wb_adr,              // Fetch address
    input logic  i_retire               // Retire strobe
);

    // Open request stays on the bus until ack
    a_req_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_wb_stb && !i_wb_ack) |=> (i_wb_cyc && i_wb_stb))
        else $error("wishbone request dropped before ack");

    // Request not yet acknowledged keeps its address
    a_adr_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_wb_cyc && i_wb_stb && !i_wb_ack) |=> $stable(i_wb_adr))
        else $error("wishbone address changed while waiting for ack");

    a_retire_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_retire |=> !i_retire)
        else $error("retire strobe high for two cycles in a row");

endmodule

bind rv_core_top rv_core_props u_props (
    .i_clk (i_clk), .i_rst_n (i_rst_n), .i_wb_ack (i_wb_ack), .i_wb_cyc (o_wb_cyc),
    .i_wb_stb (o_wb_stb), .i_wb_adr (o_wb_adr), .i_retire (o_retire)
);

//--- verification/rv_core_tb.sv
/* Core testbench with random RV32I program, Wishbone memory with wait states
   and a reference model checked at every retirement */

`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_core_tb import rv_core_pkg::*; ();

    logic      clk = 1'b0;
    logic      rst_n;
    logic      wb_ack = 1'b0;           // Driven by memory model
    word_t     wb_dat = '0;
    logic      wb_cyc, wb_stb, retire, ret_we;
    word_t     wb_adr, ret_pc, ret_data;
    reg_addr_t ret_rd;

    word_t mem [64];                    // Program wrapping every 256 bytes
    word_t m_regs [`RV_NREGS];          // Model registers
    word_t m_pc;                        // Model pc
    word_t seed;                        // LFSR state
    word_t req_adr;                     // Address seen at request start
    logic  busy, timed_out;
    int    wait_left, acks, retired, checks, errors, e0;

    rv_core_top u_dut (
        .i_clk (clk), .i_rst_n (rst_n), .i_wb_ack (wb_ack), .i_wb_dat (wb_dat),
        .o_wb_cyc (wb_cyc), .o_wb_stb (wb_stb), .o_wb_adr (wb_adr), .o_retire (retire),
        .o_ret_we (ret_we), .o_ret_pc (ret_pc), .o_ret_data (ret_data), .o_ret_rd (ret_rd)
    );

    always #10 clk = ~clk;              // 20 ns period

    function automatic word_t lfsr_next(input word_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // Right-shift Galois step
    endfunction

    // One LFSR step per bit taken
    function automatic word_t take_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            seed = lfsr_next(seed);
            v = {v[30:0], seed[0]};
        end
        return v;
    endfunction

    function automatic reg_addr_t pick_reg(input logic allow_x0_bias);
        if (allow_x0_bias && take_bits(3) == 0) return '0;    // Extra x0 writes
        return reg_addr_t'(take_bits(5));
    endfunction

    function automatic logic [2:0] pick_funct3();
        case (take_bits(2))
            32'd0:   return 3'b000;     // add, sub, addi
            32'd1:   return 3'b010;     // slt, slti
            32'd2:   return 3'b110;     // or, ori
            default: return 3'b111;     // and, andi
        endcase
    endfunction

    task automatic build_program();
        word_t kind, v, off;
        reg_addr_t rd, rs1, rs2;
        logic [2:0] f3;
        logic [6:0] f7, op;
        int t;
        for (int i = 0; i < 64; i++) begin
            kind = take_bits(4);
            rd   = pick_reg(1'b1);
            rs1  = pick_reg(1'b0);
            rs2  = pick_reg(1'b0);
            f3   = pick_funct3();
            t    = take_bits(6);                     // Branch or jump target word
            if (t == i) t = (i + 1) % 64;            // No self loops
            off  = (t - i) * 4;
            if (kind < 5) begin
                f7 = (f3 == 3'b000 && take_bits(1) != 0) ? 7'b0100000 : 7'b0000000;
                mem[i] = {f7, rs2, rs1, f3, rd, 7'b0110011};
            end else if (kind < 9) begin
                v = take_bits(12);
                mem[i] = {v[11:0], rs1, f3, rd, 7'b0010011};
            end else if (kind < 12) begin
                if (take_bits(1) != 0) rs2 = rs1;    // Half of them compare equal
                mem[i] = {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
            end else if (kind < 14) begin
                mem[i] = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
            end else begin
                v  = take_bits(25);
                op = (take_bits(1) != 0) ? 7'b0000011 : 7'b0110111;   // load or lui
                mem[i] = {v[24:0], op};
            end
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got 0x%h, expected 0x%h (model pc 0x%h)", name, got, exp, m_pc);
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got 0x%h, expected 0x%h (model pc 0x%h)", name, got, exp, m_pc);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got 0x%h, expected 0x%h (model pc 0x%h)", name, got, exp, m_pc);
        end
    endtask

    // Wishbone slave with 0 to 3 wait states per request
    always @(negedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            busy = 1'b0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;                      // cyc drops after the ack edge
        end else if (wb_cyc && wb_stb) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = take_bits(2);
                req_adr   = wb_adr;
            end
            check_word("o_wb_adr", wb_adr, req_adr);   // Held until ack
            if (wait_left == 0) begin
                wb_ack <= 1'b1;
                wb_dat <= mem[wb_adr[7:2]];
                acks++;
                busy = 1'b0;
            end else begin
                wait_left--;
            end
        end
    end

    task automatic wait_request();
        int n;
        n = 0;
        @(negedge clk);
        check_bit("o_retire", retire, 1'b0);     // Retire lasts one cycle
        while (!wb_cyc && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!wb_cyc) begin
            $display("timeout: no fetch request within 50 cycles");
            timed_out = 1'b1;
            errors++;
        end
    endtask

    task automatic wait_retire();
        int n;
        n = 0;
        while (!retire && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!retire) begin
            $display("timeout: no retirement within 50 cycles of a fetch request");
            timed_out = 1'b1;
            errors++;
        end
    endtask

    // Execute the fetched word by the ISA rules and compare the retire port
    task automatic step_model();
        word_t instr, a, b, imm, exp_data, next_pc;
        logic exp_we;
        logic is_sub;                            // R-type with funct7 0100000
        reg_addr_t rd;
        instr    = mem[m_pc[7:2]];
        rd       = instr[11:7];
        a        = m_regs[instr[19:15]];
        b        = m_regs[instr[24:20]];
        imm      = {{20{instr[31]}}, instr[31:20]};
        is_sub   = (instr[6:0] == 7'b0110011) && (instr[31:25] == 7'b0100000);
        exp_we   = 1'b0;
        exp_data = '0;
        next_pc  = m_pc + 32'd4;
        case (instr[6:0])
            7'b0110011, 7'b0010011: begin
                exp_we = 1'b1;
                if (instr[6:0] == 7'b0010011) b = imm;
                case (instr[14:12])
                    3'b000:  exp_data = is_sub ? a - b : a + b;
                    3'b010:  exp_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b110:  exp_data = a | b;
                    default: exp_data = a & b;
                endcase
            end
            7'b1100011: begin
                if (a == b) next_pc = m_pc + {{19{instr[31]}}, instr[31], instr[7],
                                              instr[30:25], instr[11:8], 1'b0};
            end
            7'b1101111: begin
                exp_we   = 1'b1;
                exp_data = m_pc + 32'd4;
                next_pc  = m_pc + {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                   instr[30:21], 1'b0};
            end
            default: ;                           // Unsupported opcode retires as nop
        endcase
        check_word("o_ret_pc", ret_pc, m_pc);
        check_bit("o_ret_we", ret_we, exp_we);
        if (exp_we) check_reg("o_ret_rd", ret_rd, rd);
        if (exp_we && rd != '0) begin
            check_word("o_ret_data", ret_data, exp_data);
            m_regs[rd] = exp_data;
        end
        m_pc = next_pc;
        retired++;
        if (acks != retired) begin
            errors++;
            $display("bus fault: %0d acks but %0d retirements", acks, retired);
        end
    endtask

    initial begin
        seed = 32'h7f30_3cc6;
        rst_n = 1'b0;
        {acks, retired, checks, errors, timed_out} = '0;
        build_program();
        m_pc = `RV_RESET_PC;
        for (int i = 0; i < `RV_NREGS; i++) m_regs[i] = '0;
        repeat (8) @(negedge clk);
        check_bit("o_wb_cyc", wb_cyc, 1'b0);
        check_bit("o_wb_stb", wb_stb, 1'b0);
        check_bit("o_retire", retire, 1'b0);
        rst_n = 1'b1;
        $display("reset test done, %0d errors", errors);
        e0 = errors;
        while (retired < 400 && !timed_out) begin
            wait_request();                      // First one checks the reset pc
            if (timed_out) break;
            check_word("o_wb_adr", wb_adr, m_pc);
            wait_retire();
            if (timed_out) break;
            step_model();
        end
        $display("program test done, %0d retirements, %0d errors", retired, errors - e0);
        $display("2 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+hw
hw/rv_core_pkg.sv
hw/maindec.sv
hw/aludec.sv
hw/controller.sv
hw/alu.sv
hw/regfile.sv
hw/pc_unit.sv
hw/fetch_fsm.sv
hw/rv_core_top.sv
verification/rv_core_props.sv
verification/rv_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the RV32I core testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module rv_core_tb -f files.f -o sim_rv_core

./obj_dir/sim_rv_core 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "RESULT: FAIL"
    exit 1
fi
echo "RESULT: PASS"
